// ==== common/sram_add_pkg.sv ====
package sram_add_pkg;

    // ----------------------------------------
    //  widths
    // ----------------------------------------

    localparam int DAT_BITS    = 32;
    localparam int LANE_BITS   = 8;
    localparam int LANES       = DAT_BITS / LANE_BITS;
    localparam int SEL_BITS    = DAT_BITS / 8;
    localparam int REGION_BITS = 2;

    // ----------------------------------------
    //  address map
    // ----------------------------------------

    // upper address bits pick the region
    localparam logic [REGION_BITS-1:0] REGION_REG  = 2'd0;
    localparam logic [REGION_BITS-1:0] REGION_MEM0 = 2'd1;
    localparam logic [REGION_BITS-1:0] REGION_MEM1 = 2'd2;
    localparam logic [REGION_BITS-1:0] REGION_MEM2 = 2'd3;

    // word offsets inside the register region
    localparam int REG_START = 0;
    localparam int REG_DONE  = 1;

    // ----------------------------------------
    //  memory word
    // ----------------------------------------

    // flat word for the bus, byte lanes for the adder
    typedef union packed {
        logic [DAT_BITS-1:0]                word;
        logic [LANES-1:0][LANE_BITS-1:0]    lane;
    } lane_word_u;

endpackage

// ==== common/wb_port_if.sv ====
`timescale 1ns/1ps

interface wb_port_if #(
    parameter int MEM_ADDR_BITS = 4
);

    logic                                   stb;
    logic                                   we;
    logic [sram_add_pkg::SEL_BITS-1:0]      sel;
    logic [MEM_ADDR_BITS-1:0]               adr;
    logic [sram_add_pkg::DAT_BITS-1:0]      dat_w;
    logic [sram_add_pkg::DAT_BITS-1:0]      dat_r;
    logic                                   ack;

    // decoder side
    modport master (
        output stb, we, sel, adr, dat_w,
        input  dat_r, ack
    );

    // memory side
    modport slave (
        input  stb, we, sel, adr, dat_w,
        output dat_r, ack
    );

endinterface

// ==== design/bus_regs.sv ====
`timescale 1ns/1ps

module bus_regs #(
    parameter int MEM_ADDR_BITS = 4
) (
    input  logic                                            s_wb_clk_i,
    input  logic                                            s_wb_rst_i,
    input  logic [MEM_ADDR_BITS+sram_add_pkg::REGION_BITS-1:0] adr_i,
    input  logic [sram_add_pkg::DAT_BITS-1:0]               dat_i,
    input  logic                                            we_i,
    input  logic [sram_add_pkg::SEL_BITS-1:0]               sel_i,
    input  logic                                            stb_i,
    output logic [sram_add_pkg::DAT_BITS-1:0]               dat_o,
    output logic                                            ack_o,
    input  logic                                            done_i,
    output logic                                            start_o,
    wb_port_if.master                                       mem0_o,
    wb_port_if.master                                       mem1_o,
    wb_port_if.master                                       mem2_o
);

    localparam int ADR_BITS = MEM_ADDR_BITS + sram_add_pkg::REGION_BITS;

    logic [sram_add_pkg::REGION_BITS-1:0]   region;
    logic [MEM_ADDR_BITS-1:0]               offset;
    logic                                   reg_stb;
    logic                                   reg_start;
    logic                                   reg_done;
    logic [sram_add_pkg::DAT_BITS-1:0]      reg_dat;

    assign region  = adr_i[ADR_BITS-1 -: sram_add_pkg::REGION_BITS];
    assign offset  = adr_i[MEM_ADDR_BITS-1:0];
    assign reg_stb = stb_i && (region == sram_add_pkg::REGION_REG);

    // ----------------------------------------
    //  memory ports
    // ----------------------------------------

    assign mem0_o.stb   = stb_i && (region == sram_add_pkg::REGION_MEM0);
    assign mem0_o.we    = we_i;
    assign mem0_o.sel   = sel_i;
    assign mem0_o.adr   = offset;
    assign mem0_o.dat_w = dat_i;

    assign mem1_o.stb   = stb_i && (region == sram_add_pkg::REGION_MEM1);
    assign mem1_o.we    = we_i;
    assign mem1_o.sel   = sel_i;
    assign mem1_o.adr   = offset;
    assign mem1_o.dat_w = dat_i;

    assign mem2_o.stb   = stb_i && (region == sram_add_pkg::REGION_MEM2);
    assign mem2_o.we    = we_i;
    assign mem2_o.sel   = sel_i;
    assign mem2_o.adr   = offset;
    assign mem2_o.dat_w = dat_i;

    // ----------------------------------------
    //  start and done registers
    // ----------------------------------------

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            reg_start <= 1'b0;
            reg_done  <= 1'b0;
        end else begin
            // start only lives for one cycle
            reg_start <= 1'b0;
            if (reg_stb && we_i && sel_i[0]) begin
                case (offset)
                    MEM_ADDR_BITS'(sram_add_pkg::REG_START): reg_start <= dat_i[0];
                    MEM_ADDR_BITS'(sram_add_pkg::REG_DONE): begin
                        if (!dat_i[0]) begin
                            reg_done <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
            // a fresh completion wins over a clear
            if (done_i) begin
                reg_done <= 1'b1;
            end
        end
    end

    always_comb begin
        reg_dat = '0;
        case (offset)
            MEM_ADDR_BITS'(sram_add_pkg::REG_START): reg_dat[0] = reg_start;
            MEM_ADDR_BITS'(sram_add_pkg::REG_DONE):  reg_dat[0] = reg_done;
            default: ;
        endcase
    end

    assign start_o = reg_start;

    // ----------------------------------------
    //  read data and ack
    // ----------------------------------------

    always_comb begin
        dat_o = '0;
        ack_o = 1'b0;
        case (region)
            sram_add_pkg::REGION_REG: begin
                dat_o = reg_dat;
                ack_o = stb_i;
            end
            sram_add_pkg::REGION_MEM0: begin
                dat_o = mem0_o.dat_r;
                ack_o = mem0_o.ack;
            end
            sram_add_pkg::REGION_MEM1: begin
                dat_o = mem1_o.dat_r;
                ack_o = mem1_o.ack;
            end
            sram_add_pkg::REGION_MEM2: begin
                dat_o = mem2_o.dat_r;
                ack_o = mem2_o.ack;
            end
            default: ;
        endcase
    end

    a_ack_needs_stb: assert property (
        @(posedge s_wb_clk_i) disable iff (s_wb_rst_i) ack_o |-> stb_i
    );

endmodule

// ==== design/operand_mem.sv ====
`timescale 1ns/1ps

module operand_mem #(
    parameter int MEM_ADDR_BITS = 4
) (
    input  logic                        s_wb_clk_i,
    input  logic                        s_wb_rst_i,
    wb_port_if.slave                    bus,
    input  logic [MEM_ADDR_BITS-1:0]    core_addr_i,
    output sram_add_pkg::lane_word_u    core_data_o
);

    localparam int MEM_WORDS = 2 ** MEM_ADDR_BITS;

    sram_add_pkg::lane_word_u   mem [MEM_WORDS];
    logic                       bus_wr;

    // write once, in the first strobe cycle
    assign bus_wr = bus.stb && bus.we && !bus.ack;

    always_ff @(posedge s_wb_clk_i) begin
        if (bus_wr) begin
            for (int i = 0; i < sram_add_pkg::LANES; i++) begin
                if (bus.sel[i]) begin
                    mem[bus.adr].lane[i] <=
                        bus.dat_w[i*sram_add_pkg::LANE_BITS +: sram_add_pkg::LANE_BITS];
                end
            end
        end
        if (bus.stb) begin
            bus.dat_r <= mem[bus.adr].word;
        end
        // core read port, one cycle latency
        core_data_o <= mem[core_addr_i];
    end

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.stb && !bus.ack;
        end
    end

    // strobe released after each ack, so one ack per access
    a_ack_pulse: assert property (
        @(posedge s_wb_clk_i) disable iff (s_wb_rst_i) bus.ack |=> !bus.stb
    );

endmodule

// ==== design/result_mem.sv ====
`timescale 1ns/1ps

module result_mem #(
    parameter int MEM_ADDR_BITS = 4
) (
    input  logic                        s_wb_clk_i,
    input  logic                        s_wb_rst_i,
    wb_port_if.slave                    bus,
    input  logic                        core_we_i,
    input  logic [MEM_ADDR_BITS-1:0]    core_addr_i,
    input  sram_add_pkg::lane_word_u    core_data_i
);

    localparam int MEM_WORDS = 2 ** MEM_ADDR_BITS;

    sram_add_pkg::lane_word_u   mem [MEM_WORDS];
    logic                       bus_wr;

    assign bus_wr = bus.stb && bus.we && !bus.ack;

    always_ff @(posedge s_wb_clk_i) begin
        if (bus_wr) begin
            for (int i = 0; i < sram_add_pkg::LANES; i++) begin
                if (bus.sel[i]) begin
                    mem[bus.adr].lane[i] <=
                        bus.dat_w[i*sram_add_pkg::LANE_BITS +: sram_add_pkg::LANE_BITS];
                end
            end
        end
        // core port writes whole words
        if (core_we_i) begin
            mem[core_addr_i] <= core_data_i;
        end
        if (bus.stb) begin
            bus.dat_r <= mem[bus.adr].word;
        end
    end

    // ack one cycle after the strobe, for one cycle
    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.stb && !bus.ack;
        end
    end

endmodule

// ==== add_core/add_core.sv ====
`timescale 1ns/1ps

module add_core #(
    parameter int MEM_ADDR_BITS = 4
) (
    input  logic                        s_wb_clk_i,
    input  logic                        s_wb_rst_i,
    input  logic                        start_i,
    output logic                        done_o,
    output logic [MEM_ADDR_BITS-1:0]    rd_addr_o,
    input  sram_add_pkg::lane_word_u    op0_i,
    input  sram_add_pkg::lane_word_u    op1_i,
    output logic                        wr_en_o,
    output logic [MEM_ADDR_BITS-1:0]    wr_addr_o,
    output sram_add_pkg::lane_word_u    wr_data_o
);

    localparam logic [MEM_ADDR_BITS-1:0] LAST_ADDR = '1;

    logic   busy;
    logic   wr_last;

    // ----------------------------------------
    //  address sequencer
    // ----------------------------------------

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            busy      <= 1'b0;
            rd_addr_o <= '0;
            wr_en_o   <= 1'b0;
            wr_last   <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            if (start_i) begin
                busy      <= 1'b1;
                rd_addr_o <= '0;
            end else if (busy) begin
                if (rd_addr_o == LAST_ADDR) begin
                    busy <= 1'b0;
                end else begin
                    rd_addr_o <= rd_addr_o + 1'b1;
                end
            end
            // valid follows the read latency
            wr_en_o <= busy;
            wr_last <= busy && (rd_addr_o == LAST_ADDR);
            done_o  <= wr_last;
        end
    end

    always_ff @(posedge s_wb_clk_i) begin
        wr_addr_o <= rd_addr_o;
    end

    // ----------------------------------------
    //  lane adder
    // ----------------------------------------

    // lanes wrap, no carry between them
    always_comb begin
        for (int i = 0; i < sram_add_pkg::LANES; i++) begin
            wr_data_o.lane[i] = op0_i.lane[i] + op1_i.lane[i];
        end
    end

    a_no_restart: assert property (
        @(posedge s_wb_clk_i) disable iff (s_wb_rst_i) start_i |-> !(busy || wr_en_o)
    );

endmodule

// ==== design/sram_add_top.sv ====
`timescale 1ns/1ps

module sram_add_top #(
    parameter int MEM_ADDR_BITS = 4
) (
    input  logic                                            s_wb_clk_i,
    input  logic                                            s_wb_rst_i,
    input  logic [MEM_ADDR_BITS+sram_add_pkg::REGION_BITS-1:0] s_wb_adr_i,
    input  logic [sram_add_pkg::DAT_BITS-1:0]               s_wb_dat_i,
    output logic [sram_add_pkg::DAT_BITS-1:0]               s_wb_dat_o,
    input  logic                                            s_wb_we_i,
    input  logic [sram_add_pkg::SEL_BITS-1:0]               s_wb_sel_i,
    input  logic                                            s_wb_stb_i,
    output logic                                            s_wb_ack_o
);

    logic                       start;
    logic                       done;
    logic [MEM_ADDR_BITS-1:0]   rd_addr;
    sram_add_pkg::lane_word_u   op0;
    sram_add_pkg::lane_word_u   op1;
    logic                       wr_en;
    logic [MEM_ADDR_BITS-1:0]   wr_addr;
    sram_add_pkg::lane_word_u   wr_data;

    wb_port_if #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) mem0_bus ();
    wb_port_if #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) mem1_bus ();
    wb_port_if #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) mem2_bus ();

    bus_regs #(
        .MEM_ADDR_BITS  (MEM_ADDR_BITS)
    ) u_bus_regs (
        .s_wb_clk_i     (s_wb_clk_i),
        .s_wb_rst_i     (s_wb_rst_i),
        .adr_i          (s_wb_adr_i),
        .dat_i          (s_wb_dat_i),
        .we_i           (s_wb_we_i),
        .sel_i          (s_wb_sel_i),
        .stb_i          (s_wb_stb_i),
        .dat_o          (s_wb_dat_o),
        .ack_o          (s_wb_ack_o),
        .done_i         (done),
        .start_o        (start),
        .mem0_o         (mem0_bus),
        .mem1_o         (mem1_bus),
        .mem2_o         (mem2_bus)
    );

    // operand memories side by side
    operand_mem #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_mem0 (
        .s_wb_clk_i     (s_wb_clk_i),
        .s_wb_rst_i     (s_wb_rst_i),
        .bus            (mem0_bus),
        .core_addr_i    (rd_addr),
        .core_data_o    (op0)
    );

    operand_mem #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_mem1 (
        .s_wb_clk_i     (s_wb_clk_i),
        .s_wb_rst_i     (s_wb_rst_i),
        .bus            (mem1_bus),
        .core_addr_i    (rd_addr),
        .core_data_o    (op1)
    );

    result_mem #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_mem2 (
        .s_wb_clk_i     (s_wb_clk_i),
        .s_wb_rst_i     (s_wb_rst_i),
        .bus            (mem2_bus),
        .core_we_i      (wr_en),
        .core_addr_i    (wr_addr),
        .core_data_i    (wr_data)
    );

    add_core #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_add_core (
        .s_wb_clk_i     (s_wb_clk_i),
        .s_wb_rst_i     (s_wb_rst_i),
        .start_i        (start),
        .done_o         (done),
        .rd_addr_o      (rd_addr),
        .op0_i          (op0),
        .op1_i          (op1),
        .wr_en_o        (wr_en),
        .wr_addr_o      (wr_addr),
        .wr_data_o      (wr_data)
    );

endmodule

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic    clk_o,
    output logic    rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset spans the first two rising edges
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

    localparam int MEM_ADDR_BITS = 4;
    localparam int ADR_BITS      = MEM_ADDR_BITS + sram_add_pkg::REGION_BITS;
    localparam int MEM_WORDS     = 2 ** MEM_ADDR_BITS;
    localparam int ACK_TIMEOUT   = 20;
    localparam int DONE_TIMEOUT  = 100;

    logic                               s_wb_clk_i;
    logic                               s_wb_rst_i;
    logic [ADR_BITS-1:0]                s_wb_adr_i;
    logic [sram_add_pkg::DAT_BITS-1:0]  s_wb_dat_i;
    logic [sram_add_pkg::DAT_BITS-1:0]  s_wb_dat_o;
    logic                               s_wb_we_i;
    logic [sram_add_pkg::SEL_BITS-1:0]  s_wb_sel_i;
    logic                               s_wb_stb_i;
    logic                               s_wb_ack_o;

    int                         error_count;
    int                         timeout_count;
    integer                     seed;
    sram_add_pkg::lane_word_u   op0_mem [MEM_WORDS];
    sram_add_pkg::lane_word_u   op1_mem [MEM_WORDS];

    tb_clk_gen u_clk_gen (
        .clk_o  (s_wb_clk_i),
        .rst_o  (s_wb_rst_i)
    );

    sram_add_top #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) sram_add_top_i (
        .s_wb_clk_i (s_wb_clk_i),
        .s_wb_rst_i (s_wb_rst_i),
        .s_wb_adr_i (s_wb_adr_i),
        .s_wb_dat_i (s_wb_dat_i),
        .s_wb_dat_o (s_wb_dat_o),
        .s_wb_we_i  (s_wb_we_i),
        .s_wb_sel_i (s_wb_sel_i),
        .s_wb_stb_i (s_wb_stb_i),
        .s_wb_ack_o (s_wb_ack_o)
    );

    // ----------------------------------------
    //  reference and compare
    // ----------------------------------------

    function automatic logic [ADR_BITS-1:0] bus_addr(
        input logic [sram_add_pkg::REGION_BITS-1:0] region,
        input int offset
    );
        return {region, offset[MEM_ADDR_BITS-1:0]};
    endfunction

    // each byte lane wraps at 256 on its own
    function automatic sram_add_pkg::lane_word_u ref_add(
        input sram_add_pkg::lane_word_u a,
        input sram_add_pkg::lane_word_u b
    );
        sram_add_pkg::lane_word_u sum;
        int lane_sum;
        for (int i = 0; i < sram_add_pkg::LANES; i++) begin
            lane_sum = int'(a.lane[i]) + int'(b.lane[i]);
            sum.lane[i] = 8'(lane_sum % 256);
        end
        return sum;
    endfunction

    task automatic check_word(
        input sram_add_pkg::lane_word_u got,
        input sram_add_pkg::lane_word_u exp,
        input string msg
    );
        if (got.word !== exp.word) begin
            error_count++;
            $display("FAIL %0t: %s got %08h expected %08h", $time, msg, got.word, exp.word);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t: %s got %b expected %b", $time, msg, got, exp);
        end
    endtask

    // ----------------------------------------
    //  bus access
    // ----------------------------------------

    // strobe held until ack, sampled on the falling edge
    task automatic bus_cycle(
        input  logic [ADR_BITS-1:0]                 adr,
        input  logic                                we,
        input  logic [sram_add_pkg::SEL_BITS-1:0]   sel,
        input  logic [sram_add_pkg::DAT_BITS-1:0]   wdata,
        output sram_add_pkg::lane_word_u            rdata,
        output logic                                acked
    );
        int wait_cycles;
        wait_cycles = 0;
        @(posedge s_wb_clk_i);
        #1;
        s_wb_adr_i = adr;
        s_wb_we_i  = we;
        s_wb_sel_i = sel;
        s_wb_dat_i = wdata;
        s_wb_stb_i = 1'b1;
        @(negedge s_wb_clk_i);
        while (s_wb_ack_o !== 1'b1 && wait_cycles < ACK_TIMEOUT) begin
            @(negedge s_wb_clk_i);
            wait_cycles++;
        end
        acked      = (s_wb_ack_o === 1'b1);
        rdata.word = s_wb_dat_o;
        if (!acked) begin
            timeout_count++;
            $display("timeout: no ack for bus access at address %0h", adr);
        end
        @(posedge s_wb_clk_i);
        #1;
        s_wb_stb_i = 1'b0;
        s_wb_we_i  = 1'b0;
    endtask

    task automatic bus_write(
        input logic [ADR_BITS-1:0]                  adr,
        input logic [sram_add_pkg::SEL_BITS-1:0]    sel,
        input logic [sram_add_pkg::DAT_BITS-1:0]    wdata
    );
        sram_add_pkg::lane_word_u unused;
        logic acked;
        bus_cycle(adr, 1'b1, sel, wdata, unused, acked);
    endtask

    task automatic bus_read(
        input  logic [ADR_BITS-1:0]         adr,
        output sram_add_pkg::lane_word_u    rdata,
        output logic                        acked
    );
        bus_cycle(adr, 1'b0, '0, '0, rdata, acked);
    endtask

    task automatic wait_done();
        sram_add_pkg::lane_word_u rd;
        logic acked;
        int polls;
        polls   = 0;
        rd.word = '0;
        while (rd.word[0] !== 1'b1 && polls < DONE_TIMEOUT) begin
            bus_read(bus_addr(sram_add_pkg::REGION_REG, sram_add_pkg::REG_DONE), rd, acked);
            polls++;
        end
        if (rd.word[0] !== 1'b1) begin
            timeout_count++;
            $display("timeout: done flag never set after start");
        end
    endtask

    // fill operands, start, wait, then compare every result word
    task automatic run_pass(input string tag);
        sram_add_pkg::lane_word_u rd;
        logic acked;
        for (int i = 0; i < MEM_WORDS; i++) begin
            op0_mem[i].word = $random(seed);
            op1_mem[i].word = $random(seed);
            bus_write(bus_addr(sram_add_pkg::REGION_MEM0, i), 4'hf, op0_mem[i].word);
            bus_write(bus_addr(sram_add_pkg::REGION_MEM1, i), 4'hf, op1_mem[i].word);
        end
        bus_write(bus_addr(sram_add_pkg::REGION_REG, sram_add_pkg::REG_START), 4'h1, 32'h1);
        wait_done();
        for (int i = 0; i < MEM_WORDS; i++) begin
            bus_read(bus_addr(sram_add_pkg::REGION_MEM2, i), rd, acked);
            check_word(rd, ref_add(op0_mem[i], op1_mem[i]),
                       $sformatf("%s result word %0d", tag, i));
        end
        bus_read(bus_addr(sram_add_pkg::REGION_REG, sram_add_pkg::REG_START), rd, acked);
        check_flag(rd.word[0], 1'b0, {tag, " start after done"});
    endtask

    // ----------------------------------------
    //  main sequence
    // ----------------------------------------

    initial begin
        sram_add_pkg::lane_word_u rd;
        sram_add_pkg::lane_word_u exp;
        logic acked;
        int wait_cycles;
        error_count   = 0;
        timeout_count = 0;
        seed          = 32'h55cf6da7;
        s_wb_adr_i    = '0;
        s_wb_dat_i    = '0;
        s_wb_we_i     = 1'b0;
        s_wb_sel_i    = '0;
        s_wb_stb_i    = 1'b0;

        wait_cycles = 0;
        while (s_wb_rst_i !== 1'b0 && wait_cycles < 20) begin
            @(negedge s_wb_clk_i);
            wait_cycles++;
        end
        if (s_wb_rst_i !== 1'b0) begin
            timeout_count++;
            $display("timeout: reset was never released");
        end

        // registers after reset
        bus_read(bus_addr(sram_add_pkg::REGION_REG, sram_add_pkg::REG_START), rd, acked);
        check_flag(rd.word[0], 1'b0, "start after reset");
        bus_read(bus_addr(sram_add_pkg::REGION_REG, sram_add_pkg::REG_DONE), rd, acked);
        check_flag(rd.word[0], 1'b0, "done after reset");
        bus_read(bus_addr(sram_add_pkg::REGION_REG, 5), rd, acked);
        check_flag(acked, 1'b1, "ack on unused register");
        exp.word = '0;
        check_word(rd, exp, "unused register data");

        // full-word and byte-select writes in every memory
        for (int r = 1; r < 4; r++) begin
            exp.word = $random(seed);
            bus_write(bus_addr(2'(r), 2), 4'hf, exp.word);
            bus_read(bus_addr(2'(r), 2), rd, acked);
            check_word(rd, exp, $sformatf("region %0d full word", r));
            bus_write(bus_addr(2'(r), 3), 4'hf, 32'h11223344);
            bus_write(bus_addr(2'(r), 3), 4'b0101, 32'haabbccdd);
            exp.word = 32'h11bb33dd;
            bus_read(bus_addr(2'(r), 3), rd, acked);
            check_word(rd, exp, $sformatf("region %0d byte select", r));
        end

        run_pass("pass 1");

        // clear done, then a second pass
        bus_write(bus_addr(sram_add_pkg::REGION_REG, sram_add_pkg::REG_DONE), 4'h1, 32'h0);
        bus_read(bus_addr(sram_add_pkg::REGION_REG, sram_add_pkg::REG_DONE), rd, acked);
        check_flag(rd.word[0], 1'b0, "done after clear");
        run_pass("pass 2");
        bus_read(bus_addr(sram_add_pkg::REGION_REG, sram_add_pkg::REG_DONE), rd, acked);
        check_flag(rd.word[0], 1'b1, "done after second pass");

        $display("errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/sram_add_pkg.sv
common/wb_port_if.sv
design/bus_regs.sv
design/operand_mem.sv
design/result_mem.sv
add_core/add_core.sv
design/sram_add_top.sv
tests/tb_clk_gen.sv
tests/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
